//--- hugepage_tx.f
rtl/hugepage_tx_pkg.sv
rtl/page_slot_ctrl.sv
rtl/write_scheduler.sv
rtl/tlp_framer.sv
rtl/hugepage_tx_top.sv
tb/pcie_sink_model.sv
tb/hugepage_tx_tb.sv

//--- rtl/hugepage_tx_pkg.sv
//////////////////////////////////////////////////
// shared widths, TLP field codes and header view for the
// huge page transmit engine, imported by RTL and testbench
//////////////////////////////////////////////////

package hugepage_tx_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////
    localparam int TRN_DW    = 64;   // trn data bus
    localparam int BUF_AW    = 9;    // 512 qword buffer
    localparam int BUF_PTR_W = 10;   // extra wrap bit
    localparam int QW_CNT_W  = 9;    // qwords per TLP
    localparam int TAG_W     = 4;    // tag bits from TLP number
    localparam int PAGE_QW_W = 32;   // qwords written into a page

    //////////////////////////////////////////////////
    // TLP fields
    //////////////////////////////////////////////////
    localparam int         PAGE_HDR_BYTES = 128;         // reserved at page start
    localparam logic [6:0] FMT_TYPE_MWR64 = 7'b110_0000; // 4DW header, with data
    localparam logic [1:0] ATTR_DATA      = 2'b11;       // relaxed ordering + no snoop
    localparam logic [1:0] ATTR_CLOSE     = 2'b01;       // no snoop only
    localparam logic [9:0] CLOSE_LEN_DW   = 10'd2;

    // framer FSM codes
    localparam logic [2:0] FR_IDLE  = 3'd0;
    localparam logic [2:0] FR_START = 3'd1;   // waits for credit, also replay entry
    localparam logic [2:0] FR_HDR   = 3'd2;
    localparam logic [2:0] FR_ADDR  = 3'd3;
    localparam logic [2:0] FR_DATA  = 3'd4;

    // first header qword of a memory write, msb first on the bus
    typedef struct packed {
        logic       rsvd0;
        logic [6:0] fmt_type;
        logic       rsvd1;
        logic [2:0] tc;            // traffic class
        logic [3:0] rsvd2;
        logic       td;            // digest present
        logic       ep;            // poisoned
        logic [1:0] attr;
        logic [1:0] rsvd3;
        logic [9:0] length;        // in DW
        logic [15:0] requester_id;
        logic [7:0] tag;
        logic [3:0] last_be;
        logic [3:0] first_be;
    } tlp_hdr_t;

    typedef union packed {
        tlp_hdr_t          hdr;
        logic [TRN_DW-1:0] raw;
    } tlp_qword_u;

endpackage

//--- rtl/hugepage_tx_top.sv
//////////////////////////////////////////////////
// huge page transmit engine as seen by the PCIe core
//////////////////////////////////////////////////
`timescale 1ns/1ps

module hugepage_tx_top (
    input  logic                                  trn_clk,
    input  logic                                  reset_n,
    input  logic                                  send_valid,
    input  logic [hugepage_tx_pkg::QW_CNT_W-1:0]  send_qwords,
    input  logic                                  send_close,
    output logic                                  send_ready,
    output logic [hugepage_tx_pkg::BUF_AW-1:0]    rd_addr,
    input  logic [63:0]                           rd_data,
    output logic [hugepage_tx_pkg::BUF_PTR_W-1:0] committed_rd_addr,
    input  logic [63:0]                           page_addr_1,
    input  logic [63:0]                           page_addr_2,
    input  logic                                  page_status_1,
    input  logic                                  page_status_2,
    output logic                                  page_free_1,
    output logic                                  page_free_2,
    output logic [hugepage_tx_pkg::TRN_DW-1:0]    trn_td,
    output logic [7:0]                            trn_trem_n,
    output logic                                  trn_tsof_n,
    output logic                                  trn_teof_n,
    output logic                                  trn_tsrc_rdy_n,
    input  logic                                  trn_tdst_rdy_n,
    input  logic [3:0]                            trn_tbuf_av,
    input  logic [15:0]                           cfg_completer_id,
    output logic                                  cfg_interrupt_n,
    input  logic                                  cfg_interrupt_rdy_n
);
    import hugepage_tx_pkg::*;

    logic                 page_valid;
    logic [63:0]          page_base;
    logic                 page_release;
    logic                 job_valid;
    logic                 job_ready;
    logic                 job_done;
    logic                 job_close;
    logic [QW_CNT_W-1:0]  job_qwords;
    logic [63:0]          job_host_addr;
    logic [BUF_PTR_W-1:0] job_buf_ptr;
    logic [TAG_W-1:0]     job_tag;
    logic [PAGE_QW_W-1:0] page_qw_count;

    page_slot_ctrl u_slots (
        .trn_clk(trn_clk), .reset_n(reset_n),
        .page_addr_1(page_addr_1), .page_addr_2(page_addr_2),
        .page_status_1(page_status_1), .page_status_2(page_status_2),
        .page_release(page_release), .page_valid(page_valid), .page_base(page_base),
        .page_free_1(page_free_1), .page_free_2(page_free_2)
    );

    write_scheduler u_sched (
        .trn_clk(trn_clk), .reset_n(reset_n),
        .page_valid(page_valid), .page_base(page_base), .page_release(page_release),
        .send_valid(send_valid), .send_qwords(send_qwords),
        .send_close(send_close), .send_ready(send_ready),
        .job_valid(job_valid), .job_close(job_close), .job_qwords(job_qwords),
        .job_host_addr(job_host_addr), .job_buf_ptr(job_buf_ptr), .job_tag(job_tag),
        .page_qw_count(page_qw_count), .job_ready(job_ready), .job_done(job_done),
        .committed_rd_addr(committed_rd_addr),
        .cfg_interrupt_n(cfg_interrupt_n), .cfg_interrupt_rdy_n(cfg_interrupt_rdy_n)
    );

    tlp_framer u_framer (
        .trn_clk(trn_clk), .reset_n(reset_n),
        .job_valid(job_valid), .job_close(job_close), .job_qwords(job_qwords),
        .job_host_addr(job_host_addr), .job_buf_ptr(job_buf_ptr), .job_tag(job_tag),
        .page_qw_count(page_qw_count), .job_ready(job_ready), .job_done(job_done),
        .rd_addr(rd_addr), .rd_data(rd_data), .cfg_completer_id(cfg_completer_id),
        .trn_td(trn_td), .trn_trem_n(trn_trem_n),
        .trn_tsof_n(trn_tsof_n), .trn_teof_n(trn_teof_n),
        .trn_tsrc_rdy_n(trn_tsrc_rdy_n), .trn_tdst_rdy_n(trn_tdst_rdy_n),
        .trn_tbuf_av(trn_tbuf_av)
    );

endmodule

//--- rtl/page_slot_ctrl.sv
//////////////////////////////////////////////////
// hands out host pages from two slots in turn and
// pulses the slot's free line when the page comes back
//////////////////////////////////////////////////
`timescale 1ns/1ps

module page_slot_ctrl (
    input  logic        trn_clk,
    input  logic        reset_n,
    input  logic [63:0] page_addr_1,
    input  logic [63:0] page_addr_2,
    input  logic        page_status_1,
    input  logic        page_status_2,
    input  logic        page_release,
    output logic        page_valid,
    output logic [63:0] page_base,
    output logic        page_free_1,
    output logic        page_free_2
);

    logic slot_sel;     // 0 waits on slot 1, 1 on slot 2
    logic slot_ready;

    assign slot_ready = slot_sel ? page_status_2 : page_status_1;

    always_ff @(posedge trn_clk or negedge reset_n) begin
        if (!reset_n) begin
            page_valid  <= 1'b0;
            slot_sel    <= 1'b0;
            page_free_1 <= 1'b0;
            page_free_2 <= 1'b0;
        end else begin
            page_free_1 <= 1'b0;                    // single cycle pulses
            page_free_2 <= 1'b0;
            if (!page_valid) begin
                if (slot_ready) begin
                    page_valid <= 1'b1;
                end
            end else if (page_release) begin
                page_valid  <= 1'b0;
                page_free_1 <= !slot_sel;           // give back the slot in use
                page_free_2 <= slot_sel;
                slot_sel    <= !slot_sel;           // then wait on the other one
            end
        end
    end

    // base is captured as the waited-on slot turns valid
    always_ff @(posedge trn_clk) begin
        if (!page_valid && slot_ready) begin
            page_base <= slot_sel ? page_addr_2 : page_addr_1;
        end
    end

endmodule

//--- rtl/tlp_framer.sv
//////////////////////////////////////////////////
// drives memory write TLPs on the trn tx bus from framer jobs,
// replays a TLP whole when the core stalled it
//////////////////////////////////////////////////
`timescale 1ns/1ps

module tlp_framer (
    input  logic                                  trn_clk,
    input  logic                                  reset_n,
    input  logic                                  job_valid,
    input  logic                                  job_close,
    input  logic [hugepage_tx_pkg::QW_CNT_W-1:0]  job_qwords,
    input  logic [63:0]                           job_host_addr,
    input  logic [hugepage_tx_pkg::BUF_PTR_W-1:0] job_buf_ptr,
    input  logic [hugepage_tx_pkg::TAG_W-1:0]     job_tag,
    input  logic [hugepage_tx_pkg::PAGE_QW_W-1:0] page_qw_count,
    output logic                                  job_ready,
    output logic                                  job_done,
    output logic [hugepage_tx_pkg::BUF_AW-1:0]    rd_addr,
    input  logic [63:0]                           rd_data,
    input  logic [15:0]                           cfg_completer_id,
    output logic [hugepage_tx_pkg::TRN_DW-1:0]    trn_td,
    output logic [7:0]                            trn_trem_n,
    output logic                                  trn_tsof_n,
    output logic                                  trn_teof_n,
    output logic                                  trn_tsrc_rdy_n,
    input  logic                                  trn_tdst_rdy_n,
    input  logic [3:0]                            trn_tbuf_av
);
    import hugepage_tx_pkg::*;

    logic [2:0]           state;
    logic                 stalled;       // core held off a beat after the header
    logic [QW_CNT_W-1:0]  qw_cnt;        // payload beats presented
    logic                 cur_close;
    logic [QW_CNT_W-1:0]  cur_qwords;
    logic [63:0]          cur_addr;
    logic [BUF_AW-1:0]    cur_ptr;       // replay start point
    logic [TAG_W-1:0]     cur_tag;
    logic [PAGE_QW_W-1:0] cur_qwc;
    tlp_qword_u           hdr_word;
    logic [63:0]          rd_swap;
    logic [31:0]          qwc_swap;

    assign job_ready  = (state == FR_IDLE);
    assign trn_trem_n = 8'h00;              // every beat is a full qword
    assign rd_swap    = {<<8{rd_data}};
    assign qwc_swap   = {<<8{cur_qwc}};

    always_comb begin
        hdr_word                  = '0;
        hdr_word.hdr.fmt_type     = FMT_TYPE_MWR64;
        hdr_word.hdr.attr         = cur_close ? ATTR_CLOSE : ATTR_DATA;
        hdr_word.hdr.length       = cur_close ? CLOSE_LEN_DW : {cur_qwords, 1'b0};
        hdr_word.hdr.requester_id = cfg_completer_id;
        hdr_word.hdr.tag          = cur_close ? 8'h00 : 8'(cur_tag);
        hdr_word.hdr.last_be      = 4'hF;
        hdr_word.hdr.first_be     = 4'hF;
    end

    // job fields, kept for replays
    always_ff @(posedge trn_clk) begin
        if (job_valid && job_ready) begin
            cur_close  <= job_close;
            cur_qwords <= job_qwords;
            cur_addr   <= job_host_addr;
            cur_ptr    <= job_buf_ptr[BUF_AW-1:0];
            cur_tag    <= job_tag;
            cur_qwc    <= page_qw_count;
        end
    end

    //////////////////////////////////////////////////
    // beat sequencing
    //////////////////////////////////////////////////
    always_ff @(posedge trn_clk or negedge reset_n) begin
        if (!reset_n) begin
            state          <= FR_IDLE;
            stalled        <= 1'b0;
            job_done       <= 1'b0;
            qw_cnt         <= '0;
            rd_addr        <= '0;
            trn_td         <= '0;
            trn_tsof_n     <= 1'b1;
            trn_teof_n     <= 1'b1;
            trn_tsrc_rdy_n <= 1'b1;
        end else begin
            job_done <= 1'b0;
            case (state)
                FR_IDLE: begin
                    if (job_valid) begin
                        state <= FR_START;
                    end
                end
                FR_START: begin
                    if (trn_tbuf_av[1] && !trn_tdst_rdy_n) begin   // credit and core ready
                        trn_td         <= hdr_word.raw;
                        trn_tsof_n     <= 1'b0;
                        trn_tsrc_rdy_n <= 1'b0;
                        rd_addr        <= cur_ptr;
                        stalled        <= 1'b0;
                        state          <= FR_HDR;
                    end
                end
                FR_HDR: begin
                    if (!trn_tdst_rdy_n) begin
                        trn_td     <= cur_addr;
                        trn_tsof_n <= 1'b1;
                        rd_addr    <= rd_addr + 1'b1;          // first qword already read
                        state      <= FR_ADDR;
                    end
                end
                FR_ADDR: begin
                    rd_addr <= rd_addr + 1'b1;                 // steps even when stalled
                    if (!trn_tdst_rdy_n) begin
                        trn_td     <= cur_close ? {qwc_swap, 32'h0} : rd_swap;
                        trn_teof_n <= !(cur_close || cur_qwords == QW_CNT_W'(1));
                        qw_cnt     <= QW_CNT_W'(1);
                        state      <= FR_DATA;
                    end else begin
                        stalled <= 1'b1;
                    end
                end
                FR_DATA: begin
                    rd_addr <= rd_addr + 1'b1;
                    if (!trn_tdst_rdy_n) begin
                        if (!trn_teof_n) begin                 // last beat went out
                            trn_teof_n     <= 1'b1;
                            trn_tsrc_rdy_n <= 1'b1;
                            if (stalled) begin
                                state <= FR_START;             // send it all again
                            end else begin
                                job_done <= 1'b1;
                                state    <= FR_IDLE;
                            end
                        end else begin
                            trn_td     <= rd_swap;
                            qw_cnt     <= qw_cnt + 1'b1;
                            trn_teof_n <= !(qw_cnt + 1'b1 == cur_qwords);
                        end
                    end else begin
                        stalled <= 1'b1;
                    end
                end
                default: state <= FR_IDLE;
            endcase
        end
    end

endmodule

//--- rtl/write_scheduler.sv
//////////////////////////////////////////////////
// turns producer requests into framer jobs, keeps the page
// offset, tag and committed pointer, raises the interrupt
//////////////////////////////////////////////////
`timescale 1ns/1ps

module write_scheduler (
    input  logic                                  trn_clk,
    input  logic                                  reset_n,
    input  logic                                  page_valid,
    input  logic [63:0]                           page_base,
    output logic                                  page_release,
    input  logic                                  send_valid,
    input  logic [hugepage_tx_pkg::QW_CNT_W-1:0]  send_qwords,
    input  logic                                  send_close,
    output logic                                  send_ready,
    output logic                                  job_valid,
    output logic                                  job_close,
    output logic [hugepage_tx_pkg::QW_CNT_W-1:0]  job_qwords,
    output logic [63:0]                           job_host_addr,
    output logic [hugepage_tx_pkg::BUF_PTR_W-1:0] job_buf_ptr,
    output logic [hugepage_tx_pkg::TAG_W-1:0]     job_tag,
    output logic [hugepage_tx_pkg::PAGE_QW_W-1:0] page_qw_count,
    input  logic                                  job_ready,
    input  logic                                  job_done,
    output logic [hugepage_tx_pkg::BUF_PTR_W-1:0] committed_rd_addr,
    output logic                                  cfg_interrupt_n,
    input  logic                                  cfg_interrupt_rdy_n
);
    import hugepage_tx_pkg::*;

    logic             page_live;     // page set up and taking data
    logic             job_pending;   // accepted, not yet done
    logic [63:0]      host_addr;     // next data write address
    logic [TAG_W-1:0] tlp_num;
    logic             send_take;

    assign send_ready  = page_live && !job_pending && cfg_interrupt_n;
    assign send_take   = send_valid && send_ready;
    assign job_tag     = tlp_num;
    assign job_buf_ptr = committed_rd_addr;   // stable while a job is out

    //////////////////////////////////////////////////
    // page and progress state
    //////////////////////////////////////////////////
    always_ff @(posedge trn_clk or negedge reset_n) begin
        if (!reset_n) begin
            page_live         <= 1'b0;
            job_valid         <= 1'b0;
            job_pending       <= 1'b0;
            page_release      <= 1'b0;
            cfg_interrupt_n   <= 1'b1;
            host_addr         <= '0;
            page_qw_count     <= '0;
            tlp_num           <= '0;
            committed_rd_addr <= '0;
        end else begin
            page_release <= 1'b0;

            // fresh page, valid still high during the release cycle
            if (page_valid && !page_live && !page_release) begin
                page_live     <= 1'b1;
                host_addr     <= page_base + 64'(PAGE_HDR_BYTES);
                page_qw_count <= '0;
            end

            if (send_take) begin
                job_valid   <= 1'b1;
                job_pending <= 1'b1;
            end else if (job_valid && job_ready) begin
                job_valid <= 1'b0;
            end

            if (!cfg_interrupt_n && !cfg_interrupt_rdy_n) begin
                cfg_interrupt_n <= 1'b1;              // core took the request
            end

            if (job_done) begin
                job_pending <= 1'b0;
                if (job_close) begin
                    page_release    <= 1'b1;
                    page_live       <= 1'b0;
                    cfg_interrupt_n <= 1'b0;
                end else begin
                    host_addr         <= host_addr + 64'({job_qwords, 3'b000});
                    tlp_num           <= tlp_num + 1'b1;
                    committed_rd_addr <= committed_rd_addr + BUF_PTR_W'(job_qwords);
                    page_qw_count     <= page_qw_count + PAGE_QW_W'(job_qwords);
                end
            end
        end
    end

    // job payload, held until the next request
    always_ff @(posedge trn_clk) begin
        if (send_take) begin
            job_close     <= send_close;
            job_qwords    <= send_qwords;
            job_host_addr <= send_close ? page_base : host_addr;  // close writes the page base
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the huge page tx testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module hugepage_tx_tb -f hugepage_tx.f \
    --Mdir obj_dir -o hugepage_tx_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/hugepage_tx_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
    echo "no result line in sim.log"
    exit 1
fi
exit 0

//--- tb/hugepage_tx_tb.sv
//////////////////////////////////////////////////
// drives producer requests into the huge page transmit engine
// and checks the collected TLPs against a reference model
//////////////////////////////////////////////////
`timescale 1ns/1ps

module hugepage_tx_tb;
    import hugepage_tx_pkg::*;

    localparam int LIMIT = 5000;   // cycles per wait

    logic        trn_clk = 1'b0;
    logic        reset_n;
    logic        send_valid;
    logic [8:0]  send_qwords;
    logic        send_close;
    logic        send_ready;
    logic [8:0]  rd_addr;
    logic [63:0] rd_data = '0;
    logic [9:0]  committed_rd_addr;
    logic [63:0] page_addr_1;
    logic [63:0] page_addr_2;
    logic        page_status_1;
    logic        page_status_2;
    logic        page_free_1;
    logic        page_free_2;
    logic [63:0] trn_td;
    logic [7:0]  trn_trem_n;
    logic        trn_tsof_n;
    logic        trn_teof_n;
    logic        trn_tsrc_rdy_n;
    logic        trn_tdst_rdy_n;
    logic [3:0]  trn_tbuf_av;
    logic [15:0] cfg_completer_id;
    logic        cfg_interrupt_n;
    logic        cfg_interrupt_rdy_n;
    logic        credit_ok;
    logic        stall_one;

    logic [63:0] mem [0:511];
    logic [63:0] exp_addr;
    logic [63:0] exp_base;
    int          exp_tag;
    int          exp_ptr;
    int          exp_qwc;
    int          errors = 0;
    int          checks = 0;
    int          free1_cnt = 0;
    int          free2_cnt = 0;

    always #50 trn_clk = ~trn_clk;

    hugepage_tx_top UUT (.*);

    pcie_sink_model sink (
        .trn_clk(trn_clk), .reset_n(reset_n), .trn_td(trn_td),
        .trn_tsof_n(trn_tsof_n), .trn_teof_n(trn_teof_n),
        .trn_tsrc_rdy_n(trn_tsrc_rdy_n), .trn_tdst_rdy_n(trn_tdst_rdy_n),
        .trn_tbuf_av(trn_tbuf_av), .cfg_interrupt_n(cfg_interrupt_n),
        .cfg_interrupt_rdy_n(cfg_interrupt_rdy_n),
        .credit_ok(credit_ok), .stall_one(stall_one)
    );

    always @(posedge trn_clk) rd_data <= #1 mem[rd_addr];   // one cycle read latency

    always @(posedge trn_clk) begin
        if (page_free_1) free1_cnt++;
        if (page_free_2) free2_cnt++;
    end

    //////////////////////////////////////////////////
    // bus rules
    //////////////////////////////////////////////////
    assert property (@(posedge trn_clk) disable iff (!reset_n)
                     !trn_tbuf_av[1] |-> trn_tsrc_rdy_n)
        else begin
            errors++;
            $display("a beat was offered while the core had no posted credit");
        end

    assert property (@(posedge trn_clk) disable iff (!reset_n)
                     !trn_tsrc_rdy_n |-> trn_trem_n == 8'h00)
        else begin
            errors++;
            $display("** Error trn_trem_n: expected 00, actual %h", trn_trem_n);
        end

    assert property (@(posedge trn_clk) disable iff (!reset_n)
                     (!cfg_interrupt_n && !cfg_interrupt_rdy_n) |=> cfg_interrupt_n)
        else begin
            errors++;
            $display("interrupt request stayed low after the core accepted it");
        end

    assert property (@(posedge trn_clk) disable iff (!reset_n)
                     $rose(cfg_interrupt_n) |-> $past(!cfg_interrupt_rdy_n))
        else begin
            errors++;
            $display("interrupt request was dropped before the core accepted it");
        end

    function automatic logic [63:0] swap_bytes(input logic [63:0] v);
        logic [63:0] r;
        for (int i = 0; i < 8; i++) r[8*i +: 8] = v[8*(7-i) +: 8];
        return r;
    endfunction

    task automatic check_val(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic give_up(input string what);
        $display("timeout while waiting for %s", what);
        $display("checks %0d, errors %0d", checks, errors + 1);
        $display("TEST FAIL");
        $finish;
    endtask

    task automatic wait_ready();
        int n = 0;
        while (!send_ready) begin
            @(posedge trn_clk);
            #1;
            n++;
            if (n > LIMIT) give_up("send_ready");
        end
    endtask

    task automatic wait_tlp(input int start);
        int n = 0;
        while (sink.got_cnt == start) begin
            @(posedge trn_clk);
            #1;
            n++;
            if (n > LIMIT) give_up("a complete TLP");
        end
    endtask

    task automatic wait_irq(input logic level);
        int n = 0;
        while (cfg_interrupt_n !== level) begin
            @(posedge trn_clk);
            #1;
            n++;
            if (n > LIMIT) give_up("cfg_interrupt_n");
        end
    endtask

    task automatic send_req(input int n, input logic close);
        wait_ready();
        send_valid  = 1'b1;
        send_qwords = 9'(n);
        send_close  = close;
        @(posedge trn_clk);
        #1;
        send_valid = 1'b0;
    endtask

    // checks one data TLP and moves the model on
    task automatic finish_data(input string name, input int n, input int prev);
        tlp_qword_u h;
        wait_tlp(prev);
        h.raw = sink.got[0];
        check_val({name, " beats"}, 64'(n + 2), 64'(sink.got_len));
        check_val({name, " fmt_type"}, 64'(FMT_TYPE_MWR64), 64'(h.hdr.fmt_type));
        check_val({name, " length"}, 64'(2 * n), 64'(h.hdr.length));
        check_val({name, " attr"}, 64'(ATTR_DATA), 64'(h.hdr.attr));
        check_val({name, " requester"}, 64'(cfg_completer_id), 64'(h.hdr.requester_id));
        check_val({name, " tag"}, 64'(exp_tag), 64'(h.hdr.tag));
        check_val({name, " byte enables"}, 64'hFF, 64'({h.hdr.last_be, h.hdr.first_be}));
        check_val({name, " address"}, exp_addr, sink.got[1]);
        for (int i = 0; i < n; i++) begin
            check_val({name, " payload"}, swap_bytes(mem[(exp_ptr + i) % 512]),
                      sink.got[i + 2]);
        end
        exp_addr = exp_addr + 64'(8 * n);
        exp_tag  = (exp_tag + 1) % 16;
        exp_ptr  = (exp_ptr + n) % 1024;
        exp_qwc  = exp_qwc + n;
        wait_ready();
        check_val({name, " committed"}, 64'(exp_ptr), 64'(committed_rd_addr));
    endtask

    task automatic run_data(input string name, input int n);
        int prev;
        prev = sink.got_cnt;
        send_req(n, 1'b0);
        finish_data(name, n, prev);
    endtask

    task automatic close_page();
        tlp_qword_u h;
        int         prev;
        int         f1;
        prev = sink.got_cnt;
        f1   = free1_cnt;
        send_req(0, 1'b1);
        wait_tlp(prev);
        h.raw = sink.got[0];
        check_val("close beats", 64'd3, 64'(sink.got_len));
        check_val("close attr", 64'(ATTR_CLOSE), 64'(h.hdr.attr));
        check_val("close length", 64'd2, 64'(h.hdr.length));
        check_val("close tag", 64'd0, 64'(h.hdr.tag));
        check_val("close address", exp_base, sink.got[1]);
        check_val("close count", swap_bytes({32'h0, 32'(exp_qwc)}), sink.got[2]);
        wait_irq(1'b0);
        wait_irq(1'b1);                             // released by the core
        repeat (2) @(posedge trn_clk);
        #1;
        check_val("page_free_1 pulses", 64'(f1 + 1), 64'(free1_cnt));
        check_val("page_free_2 pulses", 64'd0, 64'(free2_cnt));
    endtask

    initial begin
        int prev;
        int drops;
        void'($urandom(98310));
        for (int i = 0; i < 512; i++) mem[i] = {$urandom, $urandom};
        reset_n = 1'b0;
        send_valid = 1'b0;
        send_qwords = '0;
        send_close = 1'b0;
        page_addr_1 = 64'h0000_0012_3400_0000;
        page_addr_2 = 64'h0000_0056_7800_0000;
        page_status_1 = 1'b0;
        page_status_2 = 1'b0;
        cfg_completer_id = 16'h0100;
        credit_ok = 1'b1;
        stall_one = 1'b0;
        repeat (8) @(posedge trn_clk);
        #1;
        reset_n = 1'b1;

        check_val("reset tsrc_rdy_n", 64'd1, 64'(trn_tsrc_rdy_n));
        check_val("reset tsof_n", 64'd1, 64'(trn_tsof_n));
        check_val("reset teof_n", 64'd1, 64'(trn_teof_n));
        check_val("reset interrupt_n", 64'd1, 64'(cfg_interrupt_n));
        check_val("reset page_free", 64'd0, 64'({page_free_1, page_free_2}));
        repeat (10) begin
            @(posedge trn_clk);
            #1;
            check_val("send_ready before page", 64'd0, 64'(send_ready));
        end
        page_status_1 = 1'b1;
        exp_base = page_addr_1;
        exp_addr = page_addr_1 + 64'(PAGE_HDR_BYTES);
        exp_tag  = 0;
        exp_ptr  = 0;
        exp_qwc  = 0;

        run_data("single", 5);
        for (int k = 0; k < 12; k++) run_data("burst", $urandom_range(20, 90));

        //////////////////////////////////////////////////
        // replay, credits, page close
        //////////////////////////////////////////////////
        drops = sink.drop_cnt;
        stall_one = 1'b1;
        @(posedge trn_clk);
        #1;
        stall_one = 1'b0;
        run_data("replay", 17);
        check_val("stalled TLPs dropped", 64'(drops + 1), 64'(sink.drop_cnt));
        run_data("after replay", 9);

        credit_ok = 1'b0;
        prev = sink.got_cnt;
        send_req(12, 1'b0);
        repeat (12) @(posedge trn_clk);             // held while credit is gone
        #1;
        check_val("TLP without credit", 64'(prev), 64'(sink.got_cnt));
        credit_ok = 1'b1;
        finish_data("credit return", 12, prev);

        close_page();
        page_status_1 = 1'b0;
        page_status_2 = 1'b1;
        exp_base = page_addr_2;
        exp_addr = page_addr_2 + 64'(PAGE_HDR_BYTES);
        exp_qwc  = 0;
        run_data("slot 2", 7);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- tb/pcie_sink_model.sv
//////////////////////////////////////////////////
// endpoint side of the trn tx bus, collects clean TLPs,
// drops stalled ones and answers the legacy interrupt
//////////////////////////////////////////////////
`timescale 1ns/1ps

module pcie_sink_model (
    input  logic        trn_clk,
    input  logic        reset_n,
    input  logic [63:0] trn_td,
    input  logic        trn_tsof_n,
    input  logic        trn_teof_n,
    input  logic        trn_tsrc_rdy_n,
    output logic        trn_tdst_rdy_n,
    output logic [3:0]  trn_tbuf_av,
    input  logic        cfg_interrupt_n,
    output logic        cfg_interrupt_rdy_n,
    input  logic        credit_ok,        // posted credit offered
    input  logic        stall_one         // stall the next TLP once
);

    logic [63:0] cur [0:519];   // TLP being collected
    logic [63:0] got [0:519];   // last clean TLP
    int          nbeat;
    int          got_len;
    int          got_cnt;
    int          drop_cnt;
    int          int_wait;
    logic        armed;
    logic        dirty;        // sink held off a beat of this TLP
    logic        stall_now;

    initial begin
        trn_tdst_rdy_n      = 1'b0;
        trn_tbuf_av         = 4'hF;
        cfg_interrupt_rdy_n = 1'b1;
        nbeat    = 0;
        got_len  = 0;
        got_cnt  = 0;
        drop_cnt = 0;
        int_wait = 0;
        armed    = 1'b0;
        dirty    = 1'b0;
    end

    always @(posedge trn_clk) begin
        stall_now = 1'b0;
        if (stall_one) armed = 1'b1;
        if (reset_n && !trn_tsrc_rdy_n && !trn_tdst_rdy_n) begin
            if (!trn_tsof_n) begin
                nbeat = 0;
                dirty = 1'b0;
                if (armed) begin                      // hold off the address beat
                    stall_now = 1'b1;
                    armed     = 1'b0;
                    dirty     = 1'b1;
                end
            end
            if (nbeat < 520) cur[nbeat] = trn_td;
            nbeat = nbeat + 1;
            if (!trn_teof_n) begin
                if (dirty) begin
                    drop_cnt = drop_cnt + 1;          // replay will follow
                end else begin
                    for (int i = 0; i < nbeat && i < 520; i++) got[i] = cur[i];
                    got_len = nbeat;
                    got_cnt = got_cnt + 1;
                end
            end
        end
        if (!cfg_interrupt_n && cfg_interrupt_rdy_n) int_wait = int_wait + 1;
        else int_wait = 0;
        #1;
        trn_tdst_rdy_n      = stall_now;
        trn_tbuf_av         = credit_ok ? 4'hF : 4'h0;
        cfg_interrupt_rdy_n = !(int_wait == 3);   // accept after a few cycles
    end

endmodule
